// ==== hw/vdc_pkg.sv ====
// vdc_pkg: CPU register numbers, data and memory widths, default video timing
package vdc_pkg;

    // CPU visible registers, each one 16-bit word split into even/odd bytes
    typedef enum logic [3:0] {
        REG_VRAM_ADDR = 4'h0,   // vram word address
        REG_VRAM_DATA = 4'h1,   // vram data, auto increment
        REG_PAL_ADDR  = 4'h2,   // palette index
        REG_PAL_DATA  = 4'h3,   // palette colour, written on odd byte
        REG_STATUS    = 4'h4,   // busy and pending, read only
        REG_INTR      = 4'h5    // even byte mask, odd byte clear
    } reg_num_e;

    localparam int WORD_W  = 16;    // vram / palette word
    localparam int VRAM_AW = 16;    // vram word address
    localparam int PAL_AW  = 8;     // 256 palette entries
    localparam int COLOR_W = 4;     // bits per rgb channel
    localparam int INTR_N  = 4;     // bit 0 vsync, rest reserved

    // 640x480 defaults, pixels
    localparam int H_VISIBLE_DEF    = 640;
    localparam int H_TOTAL_DEF      = 800;
    localparam int H_SYNC_START_DEF = 656;
    localparam int H_SYNC_LEN_DEF   = 96;

    // lines
    localparam int V_VISIBLE_DEF    = 480;
    localparam int V_TOTAL_DEF      = 525;
    localparam int V_SYNC_START_DEF = 490;
    localparam int V_SYNC_LEN_DEF   = 2;

endpackage

// ==== hw/vram_arbiter.sv ====
// vram_arbiter: single port video RAM with fixed video priority over CPU access
`timescale 1ns/1ns

module vram_arbiter #(
    parameter int VRAM_DEPTH = 1 << vdc_pkg::VRAM_AW
) (
    input  logic                        clk,
    input  logic                        vid_req_i,      // fetcher, always wins
    input  logic [vdc_pkg::VRAM_AW-1:0] vid_addr_i,
    input  logic                        cpu_req_i,
    input  logic                        cpu_wr_i,
    input  logic [vdc_pkg::VRAM_AW-1:0] cpu_addr_i,
    input  logic [vdc_pkg::WORD_W-1:0]  cpu_wdata_i,
    output logic                        cpu_ack_o,
    output logic [vdc_pkg::WORD_W-1:0]  rdata_o         // valid cycle after grant
);
    localparam int IW = $clog2(VRAM_DEPTH);

    logic [vdc_pkg::WORD_W-1:0]  mem [VRAM_DEPTH];
    logic [vdc_pkg::VRAM_AW-1:0] mem_addr;
    logic                        mem_wr;

    assign cpu_ack_o = cpu_req_i & ~vid_req_i;          // cpu only in free cycles
    assign mem_addr  = vid_req_i ? vid_addr_i : cpu_addr_i;
    assign mem_wr    = cpu_ack_o & cpu_wr_i;            // video never writes

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_addr[IW-1:0]] <= cpu_wdata_i;
        end
        rdata_o <= mem[mem_addr[IW-1:0]];               // one cycle read, shared by both peers
    end

endmodule

// ==== hw/video_timing.sv ====
// video_timing: pixel/line counters, sync and display enable, vram pixel fetcher
`timescale 1ns/1ns

module video_timing #(
    parameter int H_VISIBLE    = vdc_pkg::H_VISIBLE_DEF,
    parameter int H_TOTAL      = vdc_pkg::H_TOTAL_DEF,
    parameter int H_SYNC_START = vdc_pkg::H_SYNC_START_DEF,
    parameter int H_SYNC_LEN   = vdc_pkg::H_SYNC_LEN_DEF,
    parameter int V_VISIBLE    = vdc_pkg::V_VISIBLE_DEF,
    parameter int V_TOTAL      = vdc_pkg::V_TOTAL_DEF,
    parameter int V_SYNC_START = vdc_pkg::V_SYNC_START_DEF,
    parameter int V_SYNC_LEN   = vdc_pkg::V_SYNC_LEN_DEF
) (
    input  logic                        clk,
    input  logic                        reset_i,
    output logic                        vid_req_o,
    output logic [vdc_pkg::VRAM_AW-1:0] vid_addr_o,
    input  logic [vdc_pkg::WORD_W-1:0]  vram_rdata_i,
    output logic [vdc_pkg::PAL_AW-1:0]  color_index_o,
    output logic                        hsync_o,        // active low
    output logic                        vsync_o,        // active low
    output logic                        de_o,
    output logic                        vsync_start_o
);
    import vdc_pkg::*;

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    logic [HW-1:0]     h_cnt;
    logic [VW-1:0]     v_cnt;
    logic [HW-1:0]     fetch_x;     // pixel fetched two ahead
    logic [VW-1:0]     fetch_y;
    logic              fetch_d;     // rdata holds our word
    logic [WORD_W-1:0] word_q;      // current pixel pair

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == HW'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // position two pixels ahead, wrapping into the next line
    always_comb begin
        if (h_cnt >= HW'(H_TOTAL - 2)) begin
            fetch_x = HW'(h_cnt + 2 - H_TOTAL);
            fetch_y = (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            fetch_x = h_cnt + 2'd2;
            fetch_y = v_cnt;
        end
    end

    // even pixel of each pair only, leaves every other cycle to the cpu
    assign vid_req_o  = ~h_cnt[0] && (fetch_x < H_VISIBLE) && (fetch_y < V_VISIBLE);
    assign vid_addr_o = VRAM_AW'(fetch_y * (H_VISIBLE / 2) + (fetch_x >> 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_d       <= 1'b0;
            hsync_o       <= 1'b1;
            vsync_o       <= 1'b1;
            de_o          <= 1'b0;
            vsync_start_o <= 1'b0;
        end else begin
            fetch_d       <= vid_req_o;
            hsync_o       <= ~((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_START + H_SYNC_LEN));
            vsync_o       <= ~((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_START + V_SYNC_LEN));
            de_o          <= (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
            vsync_start_o <= (v_cnt == VW'(V_SYNC_START)) && (h_cnt == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_d) begin
            word_q <= vram_rdata_i;                     // lands one pixel before x
        end
        // high byte for even x, low byte for odd x
        color_index_o <= h_cnt[0] ? word_q[PAL_AW-1:0] : word_q[WORD_W-1 -: PAL_AW];
    end

endmodule

// ==== hw/palette_out.sv ====
// palette_out: palette RAM, colour lookup and registered RGB/sync/enable outputs
`timescale 1ns/1ns

module palette_out (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         pal_wr_i,
    input  logic [vdc_pkg::PAL_AW-1:0]   pal_addr_i,
    input  logic [vdc_pkg::WORD_W-1:0]   pal_wdata_i,
    input  logic [vdc_pkg::PAL_AW-1:0]   color_index_i,
    input  logic                         hsync_i,
    input  logic                         vsync_i,
    input  logic                         de_i,
    output logic [vdc_pkg::COLOR_W-1:0]  red_o,
    output logic [vdc_pkg::COLOR_W-1:0]  green_o,
    output logic [vdc_pkg::COLOR_W-1:0]  blue_o,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output logic                         dv_de_o
);
    import vdc_pkg::*;

    logic [WORD_W-1:0] pal [1 << PAL_AW];   // 0RGB 4:4:4
    logic [WORD_W-1:0] colour;

    assign colour = pal[color_index_i];

    always_ff @(posedge clk) begin
        if (pal_wr_i) begin
            pal[pal_addr_i] <= pal_wdata_i;
        end
    end

    // one stage, keeps rgb aligned with syncs
    always_ff @(posedge clk) begin
        if (reset_i) begin
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            dv_de_o <= 1'b0;
        end else begin
            red_o   <= de_i ? colour[3*COLOR_W-1 -: COLOR_W] : '0;  // black in blanking
            green_o <= de_i ? colour[2*COLOR_W-1 -: COLOR_W] : '0;
            blue_o  <= de_i ? colour[COLOR_W-1:0] : '0;
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
            dv_de_o <= de_i;
        end
    end

endmodule

// ==== hw/intr_ctrl.sv ====
// intr_ctrl: pending interrupt status, mask gating, CPU interrupt strobe
`timescale 1ns/1ns

module intr_ctrl (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic [vdc_pkg::INTR_N-1:0] intr_signal_i,   // one cycle source pulses
    input  logic [vdc_pkg::INTR_N-1:0] intr_mask_i,
    input  logic [vdc_pkg::INTR_N-1:0] intr_clear_i,
    output logic [vdc_pkg::INTR_N-1:0] intr_pending_o,
    output logic                       bus_intr_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_pending_o <= '0;
            bus_intr_o     <= 1'b0;
        end else begin
            // only a new, enabled source interrupts the cpu
            bus_intr_o     <= |(intr_signal_i & intr_mask_i & ~intr_pending_o);
            intr_pending_o <= (intr_pending_o | intr_signal_i) & ~intr_clear_i;
        end
    end

endmodule

// ==== hw/vdc_regs.sv ====
// vdc_regs: CPU byte register file, vram/palette access FSM, interrupt mask/clear, status
`timescale 1ns/1ns

module vdc_regs (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        bus_cs_n_i,     // strobe, active low
    input  logic                        bus_rd_nwr_i,   // 1 = read
    input  vdc_pkg::reg_num_e           bus_reg_num_i,
    input  logic                        bus_bytesel_i,  // 0 = even (high) byte
    input  logic [7:0]                  bus_data_i,
    output logic [7:0]                  bus_data_o,
    output logic                        cpu_req_o,
    output logic                        cpu_wr_o,
    output logic [vdc_pkg::VRAM_AW-1:0] cpu_addr_o,
    output logic [vdc_pkg::WORD_W-1:0]  cpu_wdata_o,
    input  logic                        cpu_ack_i,
    input  logic [vdc_pkg::WORD_W-1:0]  cpu_rdata_i,
    output logic                        pal_wr_o,
    output logic [vdc_pkg::PAL_AW-1:0]  pal_addr_o,
    output logic [vdc_pkg::WORD_W-1:0]  pal_wdata_o,
    output logic [vdc_pkg::INTR_N-1:0]  intr_mask_o,
    output logic [vdc_pkg::INTR_N-1:0]  intr_clear_o,
    input  logic [vdc_pkg::INTR_N-1:0]  intr_pending_i
);
    import vdc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WR_WAIT,     // write waiting for grant
        ST_RD_WAIT,     // prefetch waiting for grant
        ST_RD_LOAD      // rdata valid this cycle
    } state_e;

    state_e              state_q;
    logic [VRAM_AW-1:0]  vram_addr_q;
    logic [PAL_AW-1:0]   pal_addr_q;
    logic [INTR_N-1:0]   mask_q;
    logic [7:0]          even_q;        // last even byte written
    logic [WORD_W-1:0]   wdata_q;       // assembled vram write word
    logic [WORD_W-1:0]   rbuf_q;        // prefetched vram word
    logic [WORD_W-1:0]   rd_word;
    logic                wr_strobe;
    logic                rd_strobe;
    logic                busy;

    assign wr_strobe = ~bus_cs_n_i & ~bus_rd_nwr_i;
    assign rd_strobe = ~bus_cs_n_i & bus_rd_nwr_i;
    assign busy      = (state_q != ST_IDLE);

    // arbiter request held until ack
    assign cpu_req_o   = (state_q == ST_WR_WAIT) || (state_q == ST_RD_WAIT);
    assign cpu_wr_o    = (state_q == ST_WR_WAIT);
    assign cpu_addr_o  = vram_addr_q;
    assign cpu_wdata_o = wdata_q;

    // palette written in the odd byte cycle itself
    assign pal_wr_o    = wr_strobe && bus_bytesel_i && (bus_reg_num_i == REG_PAL_DATA);
    assign pal_addr_o  = pal_addr_q;
    assign pal_wdata_o = {even_q, bus_data_i};

    assign intr_mask_o  = mask_q;
    assign intr_clear_o = (wr_strobe && bus_bytesel_i && bus_reg_num_i == REG_INTR) ?
                          bus_data_i[INTR_N-1:0] : '0;  // one cycle clear strobe

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= ST_IDLE;
            vram_addr_q <= '0;
            pal_addr_q  <= '0;
            mask_q      <= '0;
        end else begin
            case (state_q)
                ST_WR_WAIT: begin
                    if (cpu_ack_i) begin
                        vram_addr_q <= vram_addr_q + 1'b1;  // post increment
                        state_q     <= ST_IDLE;
                    end
                end
                ST_RD_WAIT: if (cpu_ack_i) state_q <= ST_RD_LOAD;
                ST_RD_LOAD: state_q <= ST_IDLE;
                default: ;
            endcase
            if (wr_strobe) begin
                case (bus_reg_num_i)
                    REG_VRAM_ADDR: begin
                        if (bus_bytesel_i) begin
                            vram_addr_q[7:0] <= bus_data_i;
                        end else begin
                            vram_addr_q[VRAM_AW-1:8] <= bus_data_i;
                        end
                        state_q <= ST_RD_WAIT;          // prefetch new address
                    end
                    REG_VRAM_DATA: if (bus_bytesel_i) state_q <= ST_WR_WAIT;
                    REG_PAL_ADDR:  if (bus_bytesel_i) pal_addr_q <= bus_data_i;
                    REG_PAL_DATA:  if (bus_bytesel_i) pal_addr_q <= pal_addr_q + 1'b1;
                    REG_INTR:      if (!bus_bytesel_i) mask_q <= bus_data_i[INTR_N-1:0];
                    default: ;
                endcase
            end else if (rd_strobe && bus_bytesel_i && bus_reg_num_i == REG_VRAM_DATA) begin
                vram_addr_q <= vram_addr_q + 1'b1;      // odd read consumes the word
                state_q     <= ST_RD_WAIT;
            end
        end
    end

    // data path, no reset
    always_ff @(posedge clk) begin
        if (wr_strobe && !bus_bytesel_i) begin
            even_q <= bus_data_i;
        end
        if (wr_strobe && bus_bytesel_i && bus_reg_num_i == REG_VRAM_DATA) begin
            wdata_q <= {even_q, bus_data_i};
        end
        if (state_q == ST_RD_LOAD) begin
            rbuf_q <= cpu_rdata_i;
        end
    end

    // readback mux
    always_comb begin
        rd_word = '0;
        case (bus_reg_num_i)
            REG_VRAM_ADDR: rd_word = vram_addr_q;
            REG_VRAM_DATA: rd_word = rbuf_q;
            REG_PAL_ADDR:  rd_word[PAL_AW-1:0] = pal_addr_q;
            REG_STATUS: begin
                rd_word[8 +: INTR_N] = intr_pending_i;
                rd_word[0]           = busy;
            end
            REG_INTR: begin
                rd_word[8 +: INTR_N] = mask_q;
                rd_word[INTR_N-1:0]  = intr_pending_i;
            end
            default: rd_word = '0;                      // PAL_DATA is write only
        endcase
        bus_data_o = bus_bytesel_i ? rd_word[7:0] : rd_word[WORD_W-1:8];
    end

endmodule

// ==== hw/vdc_top.sv ====
// vdc_top: display controller top, CPU regs and fetcher sharing vram, palette output, interrupts
`timescale 1ns/1ns

module vdc_top #(
    parameter int H_VISIBLE    = vdc_pkg::H_VISIBLE_DEF,
    parameter int H_TOTAL      = vdc_pkg::H_TOTAL_DEF,
    parameter int H_SYNC_START = vdc_pkg::H_SYNC_START_DEF,
    parameter int H_SYNC_LEN   = vdc_pkg::H_SYNC_LEN_DEF,
    parameter int V_VISIBLE    = vdc_pkg::V_VISIBLE_DEF,
    parameter int V_TOTAL      = vdc_pkg::V_TOTAL_DEF,
    parameter int V_SYNC_START = vdc_pkg::V_SYNC_START_DEF,
    parameter int V_SYNC_LEN   = vdc_pkg::V_SYNC_LEN_DEF,
    parameter int VRAM_DEPTH   = 1 << vdc_pkg::VRAM_AW
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        bus_cs_n_i,
    input  logic                        bus_rd_nwr_i,
    input  vdc_pkg::reg_num_e           bus_reg_num_i,
    input  logic                        bus_bytesel_i,
    input  logic [7:0]                  bus_data_i,
    output logic [7:0]                  bus_data_o,
    output logic                        bus_intr_o,
    output logic [vdc_pkg::COLOR_W-1:0] red_o,
    output logic [vdc_pkg::COLOR_W-1:0] green_o,
    output logic [vdc_pkg::COLOR_W-1:0] blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);
    import vdc_pkg::*;

    logic               cpu_req, cpu_wr, cpu_ack;
    logic [VRAM_AW-1:0] cpu_addr;
    logic [WORD_W-1:0]  cpu_wdata;
    logic [WORD_W-1:0]  vram_rdata;     // shared read port
    logic               vid_req;
    logic [VRAM_AW-1:0] vid_addr;
    logic               pal_wr;
    logic [PAL_AW-1:0]  pal_addr;
    logic [WORD_W-1:0]  pal_wdata;
    logic [PAL_AW-1:0]  color_index;
    logic               vt_hsync, vt_vsync, vt_de, vsync_start;
    logic [INTR_N-1:0]  intr_mask, intr_clear, intr_pending, intr_signal;

    assign intr_signal = {{(INTR_N - 1){1'b0}}, vsync_start};  // only vsync is a source

    vdc_regs vdc_regs_i (
        .clk, .reset_i,
        .bus_cs_n_i, .bus_rd_nwr_i, .bus_reg_num_i, .bus_bytesel_i, .bus_data_i, .bus_data_o,
        .cpu_req_o(cpu_req), .cpu_wr_o(cpu_wr), .cpu_addr_o(cpu_addr), .cpu_wdata_o(cpu_wdata),
        .cpu_ack_i(cpu_ack), .cpu_rdata_i(vram_rdata),
        .pal_wr_o(pal_wr), .pal_addr_o(pal_addr), .pal_wdata_o(pal_wdata),
        .intr_mask_o(intr_mask), .intr_clear_o(intr_clear), .intr_pending_i(intr_pending)
    );

    vram_arbiter #(.VRAM_DEPTH(VRAM_DEPTH)) vram_arbiter_i (
        .clk,
        .vid_req_i(vid_req), .vid_addr_i(vid_addr),
        .cpu_req_i(cpu_req), .cpu_wr_i(cpu_wr), .cpu_addr_i(cpu_addr), .cpu_wdata_i(cpu_wdata),
        .cpu_ack_o(cpu_ack), .rdata_o(vram_rdata)
    );

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
        .V_VISIBLE(V_VISIBLE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
    ) video_timing_i (
        .clk, .reset_i,
        .vid_req_o(vid_req), .vid_addr_o(vid_addr), .vram_rdata_i(vram_rdata),
        .color_index_o(color_index), .hsync_o(vt_hsync), .vsync_o(vt_vsync), .de_o(vt_de),
        .vsync_start_o(vsync_start)
    );

    palette_out palette_out_i (
        .clk, .reset_i,
        .pal_wr_i(pal_wr), .pal_addr_i(pal_addr), .pal_wdata_i(pal_wdata),
        .color_index_i(color_index), .hsync_i(vt_hsync), .vsync_i(vt_vsync), .de_i(vt_de),
        .red_o, .green_o, .blue_o, .hsync_o, .vsync_o, .dv_de_o
    );

    intr_ctrl intr_ctrl_i (
        .clk, .reset_i,
        .intr_signal_i(intr_signal), .intr_mask_i(intr_mask), .intr_clear_i(intr_clear),
        .intr_pending_o(intr_pending), .bus_intr_o
    );

endmodule

// ==== bench/vdc_tb_bus.svh ====
// bus access and busy poll tasks, vsync wait, LCG, compare tasks for bytes, words, colours, syncs, counts
`ifndef VDC_TB_BUS_SVH
`define VDC_TB_BUS_SVH

// one clock strobe, read data taken while cs is low
task automatic bus_access(input logic rd, input reg_num_e r, input logic sel,
                          input logic [7:0] wdata, output logic [7:0] rdata);
    @(posedge clk);
    bus_cs_n    <= 1'b0;
    bus_rd_nwr  <= rd;
    bus_reg_num <= r;
    bus_bytesel <= sel;
    bus_wdata   <= wdata;
    @(negedge clk);
    rdata = bus_rdata;      // combinational mux
    @(posedge clk);
    bus_cs_n <= 1'b1;       // strobe seen on this edge
endtask

task automatic poll_idle();
    logic [7:0] st;
    st = 8'h01;
    while (st[0]) begin
        bus_access(1'b1, REG_STATUS, 1'b1, 8'h00, st);    // odd byte, bit 0 busy
    end
endtask

// falling edge of vsync_o, then a little slack for the interrupt strobe
task automatic wait_vsync();
    @(negedge clk);
    while (!vsync) @(negedge clk);
    while (vsync) @(negedge clk);
    repeat (2) @(posedge clk);
endtask

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        fail_stop($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                          input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
        fail_stop($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic check_color(input string name, input logic [COLOR_W-1:0] got,
                           input logic [COLOR_W-1:0] exp);
    if (got !== exp) begin
        fail_stop($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
endtask

// single bit video outputs, syncs and enable
task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_stop($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        fail_stop($sformatf("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
    end
endtask

`endif

// ==== bench/vdc_tb.sv ====
// vdc_tb: testbench top, clock/reset, DUT in a small video mode, table driven bus stimulus, monitors
`timescale 1ns/1ns

module vdc_tb;
    import vdc_pkg::*;

    // small mode so a frame is only 240 clocks
    localparam int H_VIS        = 16;
    localparam int H_TOT        = 24;
    localparam int H_SYNC_ST    = 18;
    localparam int H_SYNC_W     = 2;
    localparam int V_VIS        = 6;
    localparam int V_TOT        = 10;
    localparam int V_SYNC_ST    = 7;
    localparam int V_SYNC_W     = 1;
    localparam int FRAME_CYCLES = H_TOT * V_TOT;
    localparam int DISP_WORDS   = V_VIS * H_VIS / 2;   // two pixels per vram word

    typedef enum logic [2:0] {
        OP_WR,          // byte write
        OP_RD,          // byte read, compare
        OP_RDWORD,      // even then odd read, compare word
        OP_POLL,        // read status until not busy
        OP_BUSY,        // status must still show busy
        OP_FRAME,       // wait for next vsync
        OP_IRQS,        // interrupt pulses since last check
        OP_PIXON        // arm pixel checking
    } op_e;

    logic              clk = 1'b0;
    logic              reset_i;
    logic              bus_cs_n;
    logic              bus_rd_nwr;
    reg_num_e          bus_reg_num;
    logic              bus_bytesel;
    logic [7:0]        bus_wdata;
    logic [7:0]        bus_rdata;
    logic              bus_intr;
    logic [COLOR_W-1:0] red, green, blue;
    logic              hsync, vsync, dv_de;

    // stimulus table, one column per queue
    op_e               op_q[$];
    reg_num_e          reg_q[$];
    logic              sel_q[$];
    logic [WORD_W-1:0] data_q[$];

    logic [WORD_W-1:0] vram_model [DISP_WORDS];
    logic [WORD_W-1:0] pal_model [1 << PAL_AW];
    logic [31:0]       rng_state;
    int                cycle_cnt   = 0;
    int                cycle_limit = 0;    // set once the table is built
    int                intr_pulses = 0;
    int                irq_base    = 0;
    int                pix_checked = 0;
    int                line        = 0;
    int                px          = 0;
    int                frame_pos   = -1;   // clocks since top left pixel
    logic              pix_check_on = 1'b0;
    logic              armed        = 1'b0;

    always #10 clk = ~clk;

    vdc_top #(
        .H_VISIBLE(H_VIS), .H_TOTAL(H_TOT), .H_SYNC_START(H_SYNC_ST), .H_SYNC_LEN(H_SYNC_W),
        .V_VISIBLE(V_VIS), .V_TOTAL(V_TOT), .V_SYNC_START(V_SYNC_ST), .V_SYNC_LEN(V_SYNC_W),
        .VRAM_DEPTH(256)
    ) vdc_top_i (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr), .bus_reg_num_i(bus_reg_num),
        .bus_bytesel_i(bus_bytesel), .bus_data_i(bus_wdata), .bus_data_o(bus_rdata),
        .bus_intr_o(bus_intr), .red_o(red), .green_o(green), .blue_o(blue),
        .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de)
    );

    `include "vdc_tb_bus.svh"

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic add_op(input op_e op, input reg_num_e r, input logic sel,
                          input logic [WORD_W-1:0] d);
        op_q.push_back(op);
        reg_q.push_back(r);
        sel_q.push_back(sel);
        data_q.push_back(d);
    endtask

    task automatic build_table();
        logic [WORD_W-1:0] w;
        add_op(OP_WR, REG_VRAM_ADDR, 1'b0, 16'h0000);     // start at word 0
        add_op(OP_POLL, REG_STATUS, 1'b1, 16'h0000);
        add_op(OP_WR, REG_VRAM_ADDR, 1'b1, 16'h0000);
        add_op(OP_POLL, REG_STATUS, 1'b1, 16'h0000);
        for (int i = 0; i < DISP_WORDS; i++) begin
            rng_state = lcg_next(rng_state);
            w = rng_state[31:16];
            vram_model[i] = w;
            add_op(OP_WR, REG_VRAM_DATA, 1'b0, {8'h00, w[15:8]});
            add_op(OP_WR, REG_VRAM_DATA, 1'b1, {8'h00, w[7:0]});   // odd byte writes the word
            add_op(OP_POLL, REG_STATUS, 1'b1, 16'h0000);
        end
        add_op(OP_RDWORD, REG_VRAM_ADDR, 1'b0, 16'(DISP_WORDS));   // one step per write
        // readback through the prefetch buffer
        add_op(OP_WR, REG_VRAM_ADDR, 1'b0, 16'h0000);
        add_op(OP_POLL, REG_STATUS, 1'b1, 16'h0000);
        add_op(OP_WR, REG_VRAM_ADDR, 1'b1, 16'h0000);
        add_op(OP_BUSY, REG_STATUS, 1'b1, 16'h0000);
        add_op(OP_POLL, REG_STATUS, 1'b1, 16'h0000);
        for (int i = 0; i < DISP_WORDS; i++) begin
            add_op(OP_RDWORD, REG_VRAM_DATA, 1'b0, vram_model[i]);
            add_op(OP_BUSY, REG_STATUS, 1'b1, 16'h0000);   // odd read started a prefetch
            add_op(OP_POLL, REG_STATUS, 1'b1, 16'h0000);
        end
        add_op(OP_RDWORD, REG_VRAM_ADDR, 1'b0, 16'(DISP_WORDS));
        // whole palette, index auto increments
        add_op(OP_WR, REG_PAL_ADDR, 1'b1, 16'h0000);
        for (int i = 0; i < (1 << PAL_AW); i++) begin
            rng_state = lcg_next(rng_state);
            w = {4'h0, rng_state[27:16]};                  // 0RGB
            pal_model[i] = w;
            add_op(OP_WR, REG_PAL_DATA, 1'b0, {8'h00, w[15:8]});
            add_op(OP_WR, REG_PAL_DATA, 1'b1, {8'h00, w[7:0]});
        end
        add_op(OP_PIXON, REG_STATUS, 1'b0, 16'h0000);
        add_op(OP_FRAME, REG_STATUS, 1'b0, 16'h0000);
        // masked off, pending only
        add_op(OP_WR, REG_INTR, 1'b0, 16'h0000);
        add_op(OP_WR, REG_INTR, 1'b1, 16'h000f);
        add_op(OP_IRQS, REG_INTR, 1'b0, 16'd0);
        add_op(OP_FRAME, REG_STATUS, 1'b0, 16'h0000);
        add_op(OP_IRQS, REG_INTR, 1'b0, 16'd0);
        add_op(OP_RD, REG_STATUS, 1'b0, 16'h0001);        // vsync pending
        // mask on while pending, then clear
        add_op(OP_WR, REG_INTR, 1'b0, 16'h0001);
        add_op(OP_WR, REG_INTR, 1'b1, 16'h0001);
        add_op(OP_IRQS, REG_INTR, 1'b0, 16'd0);
        add_op(OP_FRAME, REG_STATUS, 1'b0, 16'h0000);
        add_op(OP_IRQS, REG_INTR, 1'b0, 16'd1);
        add_op(OP_WR, REG_INTR, 1'b1, 16'h0001);
        add_op(OP_FRAME, REG_STATUS, 1'b0, 16'h0000);
        add_op(OP_IRQS, REG_INTR, 1'b0, 16'd1);
        // left pending, so nothing more
        add_op(OP_FRAME, REG_STATUS, 1'b0, 16'h0000);
        add_op(OP_IRQS, REG_INTR, 1'b0, 16'd0);
        add_op(OP_FRAME, REG_STATUS, 1'b0, 16'h0000);
        add_op(OP_IRQS, REG_INTR, 1'b0, 16'd0);
        add_op(OP_RD, REG_STATUS, 1'b0, 16'h0001);
    endtask

    task automatic apply_op(input op_e op, input reg_num_e r, input logic sel,
                            input logic [WORD_W-1:0] d);
        logic [7:0] hi;
        logic [7:0] lo;
        case (op)
            OP_WR: bus_access(1'b0, r, sel, d[7:0], lo);
            OP_RD: begin
                bus_access(1'b1, r, sel, 8'h00, lo);
                check_byte($sformatf("bus_data_o (%s)", r.name()), lo, d[7:0]);
            end
            OP_RDWORD: begin
                bus_access(1'b1, r, 1'b0, 8'h00, hi);
                bus_access(1'b1, r, 1'b1, 8'h00, lo);
                check_word($sformatf("bus_data_o word (%s)", r.name()), {hi, lo}, d);
            end
            OP_POLL: poll_idle();
            OP_BUSY: begin
                bus_access(1'b1, REG_STATUS, 1'b1, 8'h00, lo);
                check_byte("STATUS busy bit", lo & 8'h01, 8'h01);
            end
            OP_FRAME: wait_vsync();
            OP_IRQS: begin
                check_count("bus_intr_o pulses", intr_pulses - irq_base, int'(d));
                irq_base = intr_pulses;
            end
            default: pix_check_on = 1'b1;
        endcase
    endtask

    // hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            fail_stop($sformatf("Timeout: the test table did not finish in %0d cycles",
                                cycle_limit));
        end
    end

    // pixels, blanking and interrupt pulses, sampled mid cycle
    always @(negedge clk) begin : output_monitor
        logic [WORD_W-1:0] word;
        logic [WORD_W-1:0] colour;
        logic [PAL_AW-1:0] index;
        if (!reset_i) begin
            if (bus_intr) intr_pulses++;
            if (!dv_de) begin
                check_color("red_o", red, '0);            // blanking is black
                check_color("green_o", green, '0);
                check_color("blue_o", blue, '0);
            end
            if (!vsync) begin
                line  = 0;
                px    = 0;
                armed = pix_check_on;                     // count from the next frame
            end else if (armed && dv_de) begin
                if (line >= V_VIS) fail_stop("display enable was seen below the visible lines");
                word   = vram_model[line * (H_VIS / 2) + px / 2];
                index  = (px % 2 == 1) ? word[7:0] : word[15:8];    // even x takes high byte
                colour = pal_model[index];
                check_color("red_o", red, colour[11:8]);
                check_color("green_o", green, colour[7:4]);
                check_color("blue_o", blue, colour[3:0]);
                pix_checked++;
                px++;
                if (px == H_VIS) begin
                    px = 0;
                    line++;
                end
            end
        end
    end

    // sync and enable timing, frame position free runs from the first enabled pixel
    always @(negedge clk) begin : timing_monitor
        int h;
        int v;
        if (reset_i) begin
            frame_pos = -1;
        end else begin
            if (frame_pos >= 0) begin
                frame_pos = (frame_pos + 1) % FRAME_CYCLES;
            end else if (dv_de) begin
                frame_pos = 0;                          // line 0, pixel 0
            end
            if (frame_pos >= 0) begin
                h = frame_pos % H_TOT;
                v = frame_pos / H_TOT;
                check_bit("hsync_o", hsync, !(h >= H_SYNC_ST && h < H_SYNC_ST + H_SYNC_W));
                check_bit("vsync_o", vsync, !(v >= V_SYNC_ST && v < V_SYNC_ST + V_SYNC_W));
                check_bit("dv_de_o", dv_de, h < H_VIS && v < V_VIS);
            end
        end
    end

    initial begin : main_sequence
        reset_i     = 1'b1;
        bus_cs_n    = 1'b1;
        bus_rd_nwr  = 1'b1;
        bus_reg_num = REG_STATUS;
        bus_bytesel = 1'b0;
        bus_wdata   = 8'h00;
        rng_state   = 32'h63ad5dcd;
        build_table();
        cycle_limit = op_q.size() * 40 + 3 * FRAME_CYCLES;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        for (int i = 0; i < op_q.size(); i++) begin
            apply_op(op_q[i], reg_q[i], sel_q[i], data_q[i]);
        end
        if (pix_checked < H_VIS * V_VIS) begin
            fail_stop("the pixel monitor never saw a complete visible frame");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
+incdir+bench
hw/vdc_pkg.sv
hw/vram_arbiter.sv
hw/video_timing.sv
hw/palette_out.sv
hw/intr_ctrl.sv
hw/vdc_regs.sv
hw/vdc_top.sv
bench/vdc_tb.sv

// ==== Makefile ====
# Verilator build and run for the video display controller testbench

VERILATOR ?= verilator
TOP       ?= vdc_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -Wno-fatal

SOURCES := $(wildcard hw/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "RESULT: PASS" || (echo "RESULT: FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
